// File: design/kernel_cfg.svh
`ifndef KERNEL_CFG_SVH
`define KERNEL_CFG_SVH

// stream beat width in bits
`define PHIT_W 128

// float-width lanes per phit
`define LANES 4
`define LANE_W 32

// coefficient vectors held in the bank, 4-bit address
`define COEF_DEPTH 16

// entries per buffer FIFO, input side and output side alike
`define FIFO_DEPTH 16

`endif

// File: design/kernel_pkg.sv
`default_nettype none

`include "kernel_cfg.svh"

package kernel_pkg;

    // one stream beat and its byte keep
    typedef logic [`PHIT_W-1:0]   phit_t;
    typedef logic [`PHIT_W/8-1:0] keep_t;

    // one valid bit per 32-bit lane
    typedef logic [`LANES-1:0] lane_mask_t;

    typedef logic [$clog2(`COEF_DEPTH)-1:0] coef_addr_t;

    // steady-state controller
    typedef enum logic {
        STEADY_OFF = 1'b0,
        STEADY_ON  = 1'b1
    } steady_t;

endpackage

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "kernel_cfg.svh"

module sync_fifo #(
    parameter int WIDTH = 32
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             i_push,
    input  wire logic             i_pop,
    input  wire logic [WIDTH-1:0] i_din,
    output logic      [WIDTH-1:0] o_dout,
    output logic                  o_empty,
    output logic                  o_full
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    logic [WIDTH-1:0] mem [`FIFO_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;  // push on full is dropped
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    // first word falls through, head is always on the output
    assign o_dout  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(`FIFO_DEPTH));

endmodule

`default_nettype wire

// File: design/stream_in_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "kernel_cfg.svh"

module stream_in_buffer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    i_steady,
    // incoming stream
    input  wire kernel_pkg::phit_t       i_tdata,
    input  wire kernel_pkg::keep_t       i_tkeep,
    input  wire logic                    i_tvalid,
    input  wire logic                    i_tlast,
    output logic                         o_tready,
    // head of buffer towards the multiplier
    input  wire logic                    i_consume,
    output kernel_pkg::phit_t            o_data,
    output kernel_pkg::lane_mask_t       o_lane_valid,
    output logic                         o_last,
    output logic                         o_avail
);

    import kernel_pkg::*;

    localparam int BUF_W = `PHIT_W + `LANES + 1;

    lane_mask_t       lane_valid;
    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic [BUF_W-1:0] fifo_dout;

    // a lane counts only with all four keep bits set
    always_comb begin
        for (int k = 0; k < `LANES; k++) begin
            lane_valid[k] = &i_tkeep[k*4 +: 4];
        end
    end

    assign o_tready = i_steady && !fifo_full;  // held low in passthrough
    assign push     = i_tvalid && o_tready;

    sync_fifo #(
        .WIDTH(BUF_W)
    ) in_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_pop   (i_consume),
        .i_din   ({i_tlast, lane_valid, i_tdata}),
        .o_dout  (fifo_dout),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    assign o_data       = fifo_dout[`PHIT_W-1:0];
    assign o_lane_valid = fifo_dout[`PHIT_W +: `LANES];
    assign o_last       = fifo_dout[BUF_W-1];
    assign o_avail      = !fifo_empty;

endmodule

`default_nettype wire

// File: design/coef_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "kernel_cfg.svh"

module coef_bank (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  i_steady,
    // load port, only honoured outside steady state
    input  wire logic                  i_we,
    input  wire kernel_pkg::coef_addr_t i_waddr,
    input  wire kernel_pkg::phit_t     i_wdata,
    // read side follows the input FIFO head
    input  wire logic                  i_consume,
    output kernel_pkg::phit_t          o_coef
);

    import kernel_pkg::*;

    phit_t      bank [`COEF_DEPTH];
    coef_addr_t rd_addr;
    logic       steady_q;
    logic       steady_rise;

    assign steady_rise = i_steady && !steady_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            steady_q <= 1'b0;
            rd_addr  <= '0;
        end else begin
            steady_q <= i_steady;
            if (steady_rise) begin
                rd_addr <= '0;  // every steady period starts at entry 0
            end else if (i_consume) begin
                rd_addr <= rd_addr + 1'b1;  // wraps at 16
            end
        end
    end

    // writes while steady are ignored
    always_ff @(posedge clk) begin
        if (i_we && !i_steady) begin
            bank[i_waddr] <= i_wdata;
        end
    end

    assign o_coef = bank[rd_addr];

endmodule

`default_nettype wire

// File: design/lane_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "kernel_cfg.svh"

module lane_multiplier (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // operand beat from the input buffer
    input  wire logic                    i_avail,
    input  wire kernel_pkg::phit_t       i_data,
    input  wire kernel_pkg::lane_mask_t  i_lane_valid,
    input  wire logic                    i_last,
    input  wire kernel_pkg::phit_t       i_coef,
    output logic                         o_consume,
    // processed stream
    input  wire logic                    i_tready,
    output kernel_pkg::phit_t            o_tdata,
    output kernel_pkg::keep_t            o_tkeep,
    output logic                         o_tvalid,
    output logic                         o_tlast
);

    import kernel_pkg::*;

    localparam int OUT_W = `PHIT_W + `LANES + 1;

    logic             advance;
    logic             out_full;
    logic             out_empty;
    logic [OUT_W-1:0] out_dout;
    lane_mask_t       out_mask;

    // stage 1 operands
    logic       s1_valid;
    phit_t      s1_data;
    phit_t      s1_coef;
    lane_mask_t s1_mask;
    logic       s1_last;
    phit_t      s1_prod;

    // stage 2 masked product
    logic       s2_valid;
    phit_t      s2_prod;
    lane_mask_t s2_mask;
    logic       s2_last;

    assign advance   = !out_full;  // whole pipe freezes on full
    assign o_consume = advance && i_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= i_avail;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_data <= i_data;
            s1_coef <= i_coef;
            s1_mask <= i_lane_valid;
            s1_last <= i_last;
            s2_prod <= s1_prod;
            s2_mask <= s1_mask;
            s2_last <= s1_last;
        end
    end

    // low 32 bits per lane, dead lanes forced to zero
    always_comb begin
        for (int k = 0; k < `LANES; k++) begin
            if (s1_mask[k]) begin
                s1_prod[k*`LANE_W +: `LANE_W] =
                    s1_data[k*`LANE_W +: `LANE_W] * s1_coef[k*`LANE_W +: `LANE_W];
            end else begin
                s1_prod[k*`LANE_W +: `LANE_W] = '0;
            end
        end
    end

    sync_fifo #(
        .WIDTH(OUT_W)
    ) out_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .i_push  (advance && s2_valid),
        .i_pop   (i_tready),
        .i_din   ({s2_last, s2_mask, s2_prod}),
        .o_dout  (out_dout),
        .o_empty (out_empty),
        .o_full  (out_full)
    );

    assign o_tdata  = out_dout[`PHIT_W-1:0];
    assign out_mask = out_dout[`PHIT_W +: `LANES];
    assign o_tlast  = out_dout[OUT_W-1];
    assign o_tvalid = !out_empty;

    always_comb begin
        for (int k = 0; k < `LANES; k++) begin
            o_tkeep[k*4 +: 4] = {4{out_mask[k]}};  // one keep group per lane
        end
    end

endmodule

`default_nettype wire

// File: design/steady_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module steady_bypass (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_done_loader,
    input  wire logic              i_ap_done,
    output logic                   o_steady,
    // raw stream for passthrough
    input  wire kernel_pkg::phit_t i_tdata,
    input  wire kernel_pkg::keep_t i_tkeep,
    input  wire logic              i_tvalid,
    input  wire logic              i_tlast,
    input  wire logic              i_tready_out,
    // processed stream and buffer ready
    input  wire kernel_pkg::phit_t i_proc_tdata,
    input  wire kernel_pkg::keep_t i_proc_tkeep,
    input  wire logic              i_proc_tvalid,
    input  wire logic              i_proc_tlast,
    input  wire logic              i_proc_tready,
    // selected output
    output kernel_pkg::phit_t      o_tdata,
    output kernel_pkg::keep_t      o_tkeep,
    output logic                   o_tvalid,
    output logic                   o_tlast,
    output logic                   o_tready_in
);

    import kernel_pkg::*;

    steady_t state;
    steady_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STEADY_OFF;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            STEADY_OFF: state_next = i_done_loader ? STEADY_ON : STEADY_OFF;
            STEADY_ON:  state_next = i_ap_done ? STEADY_OFF : STEADY_ON;
            default:    state_next = STEADY_OFF;
        endcase
    end

    assign o_steady = (state == STEADY_ON);

    // passthrough is combinational, no added delay
    assign o_tdata     = o_steady ? i_proc_tdata : i_tdata;
    assign o_tkeep     = o_steady ? i_proc_tkeep : i_tkeep;
    assign o_tvalid    = o_steady ? i_proc_tvalid : i_tvalid;
    assign o_tlast     = o_steady ? i_proc_tlast : i_tlast;
    assign o_tready_in = o_steady ? i_proc_tready : i_tready_out;

endmodule

`default_nettype wire

// File: design/stream_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module stream_kernel (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   i_done_loader,
    input  wire logic                   i_ap_done,
    // coefficient load port
    input  wire logic                   i_coef_we,
    input  wire kernel_pkg::coef_addr_t i_coef_addr,
    input  wire kernel_pkg::phit_t      i_coef_wdata,
    // stream in
    input  wire kernel_pkg::phit_t      i_tdata_in,
    input  wire kernel_pkg::keep_t      i_tkeep_in,
    input  wire logic                   i_tvalid_in,
    input  wire logic                   i_tlast_in,
    output logic                        o_tready_in,
    // stream out
    output kernel_pkg::phit_t           o_tdata_out,
    output kernel_pkg::keep_t           o_tkeep_out,
    output logic                        o_tvalid_out,
    output logic                        o_tlast_out,
    input  wire logic                   i_tready_out,
    output logic                        o_done_steady
);

    import kernel_pkg::*;

    logic       steady;
    logic       consume;
    // input buffer head
    phit_t      buf_data;
    lane_mask_t buf_lane_valid;
    logic       buf_last;
    logic       buf_avail;
    logic       buf_tready;
    phit_t      coef;
    // processed stream
    phit_t      proc_tdata;
    keep_t      proc_tkeep;
    logic       proc_tvalid;
    logic       proc_tlast;

    stream_in_buffer stream_in_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .i_steady     (steady),
        .i_tdata      (i_tdata_in),
        .i_tkeep      (i_tkeep_in),
        .i_tvalid     (i_tvalid_in),
        .i_tlast      (i_tlast_in),
        .o_tready     (buf_tready),
        .i_consume    (consume),
        .o_data       (buf_data),
        .o_lane_valid (buf_lane_valid),
        .o_last       (buf_last),
        .o_avail      (buf_avail)
    );

    coef_bank coef_bank_i (
        .clk       (clk),
        .rst       (rst),
        .i_steady  (steady),
        .i_we      (i_coef_we),
        .i_waddr   (i_coef_addr),
        .i_wdata   (i_coef_wdata),
        .i_consume (consume),  // same strobe that pops the input FIFO
        .o_coef    (coef)
    );

    lane_multiplier lane_multiplier_i (
        .clk          (clk),
        .rst          (rst),
        .i_avail      (buf_avail),
        .i_data       (buf_data),
        .i_lane_valid (buf_lane_valid),
        .i_last       (buf_last),
        .i_coef       (coef),
        .o_consume    (consume),
        .i_tready     (i_tready_out),
        .o_tdata      (proc_tdata),
        .o_tkeep      (proc_tkeep),
        .o_tvalid     (proc_tvalid),
        .o_tlast      (proc_tlast)
    );

    steady_bypass steady_bypass_i (
        .clk           (clk),
        .rst           (rst),
        .i_done_loader (i_done_loader),
        .i_ap_done     (i_ap_done),
        .o_steady      (steady),
        .i_tdata       (i_tdata_in),
        .i_tkeep       (i_tkeep_in),
        .i_tvalid      (i_tvalid_in),
        .i_tlast       (i_tlast_in),
        .i_tready_out  (i_tready_out),
        .i_proc_tdata  (proc_tdata),
        .i_proc_tkeep  (proc_tkeep),
        .i_proc_tvalid (proc_tvalid),
        .i_proc_tlast  (proc_tlast),
        .i_proc_tready (buf_tready),
        .o_tdata       (o_tdata_out),
        .o_tkeep       (o_tkeep_out),
        .o_tvalid      (o_tvalid_out),
        .o_tlast       (o_tlast_out),
        .o_tready_in   (o_tready_in)
    );

    assign o_done_steady = steady;

endmodule

`default_nettype wire

// File: tb/stream_kernel_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stream_kernel_checker (
    input wire logic              clk,
    input wire logic              rst,
    input wire kernel_pkg::phit_t i_tdata_in,
    input wire kernel_pkg::keep_t i_tkeep_in,
    input wire logic              i_tvalid_in,
    input wire logic              i_tlast_in,
    input wire logic              o_tready_in,
    input wire kernel_pkg::phit_t o_tdata_out,
    input wire kernel_pkg::keep_t o_tkeep_out,
    input wire logic              o_tvalid_out,
    input wire logic              o_tlast_out,
    input wire logic              i_tready_out,
    input wire logic              o_done_steady
);

    import kernel_pkg::*;

    int assert_failures = 0;  // failed assertions so far

    // each lane keep group is all ones or all zeros
    function automatic logic keep_uniform(input keep_t keep);
        logic ok;
        ok = 1'b1;
        for (int g = 0; g < $bits(keep_t) / 4; g++) begin
            if (keep[g*4 +: 4] != 4'h0 && keep[g*4 +: 4] != 4'hf) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    reset_clears_steady: assert property (@(posedge clk) rst |=> !o_done_steady)
        else begin
            assert_failures++;
            $error("o_done_steady high right after reset");
        end

    // a stalled output beat may not change until it is taken
    stall_holds_beat: assert property (@(posedge clk) disable iff (rst)
        o_done_steady && o_tvalid_out && !i_tready_out |=>
            !o_done_steady || (o_tvalid_out && $stable(o_tdata_out) &&
                               $stable(o_tkeep_out) && $stable(o_tlast_out)))
        else begin
            assert_failures++;
            $error("output beat changed while stalled");
        end

    passthrough_equal: assert property (@(posedge clk) disable iff (rst)
        !o_done_steady |-> (o_tdata_out == i_tdata_in) && (o_tkeep_out == i_tkeep_in) &&
            (o_tvalid_out == i_tvalid_in) && (o_tlast_out == i_tlast_in) &&
            (o_tready_in == i_tready_out))
        else begin
            assert_failures++;
            $error("passthrough output differs from input");
        end

    keep_groups_uniform: assert property (@(posedge clk) disable iff (rst)
        o_done_steady && o_tvalid_out |-> keep_uniform(o_tkeep_out))
        else begin
            assert_failures++;
            $error("processed keep group not uniform");
        end

endmodule

bind stream_kernel stream_kernel_checker stream_kernel_checker_i (.*);

`default_nettype wire

// File: tb/tb_stream_kernel.sv
`timescale 1ns/1ps
`default_nettype none

`include "kernel_cfg.svh"

module tb_stream_kernel;

    import kernel_pkg::*;

    // passthrough 24 + 8, multiply 20, partial keep 16, back-pressure 40
    localparam int TOTAL_BEATS     = 108;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

    logic       clk;
    logic       rst;
    logic       i_done_loader;
    logic       i_ap_done;
    logic       i_coef_we;
    coef_addr_t i_coef_addr;
    phit_t      i_coef_wdata;
    phit_t      i_tdata_in;
    keep_t      i_tkeep_in;
    logic       i_tvalid_in;
    logic       i_tlast_in;
    logic       o_tready_in;
    phit_t      o_tdata_out;
    keep_t      o_tkeep_out;
    logic       o_tvalid_out;
    logic       o_tlast_out;
    logic       i_tready_out;
    logic       o_done_steady;

    logic [31:0] lfsr_state = 32'hf134_68b4;
    phit_t       coef_model [`COEF_DEPTH];
    phit_t       exp_data [$];  // reference queue of expected beats
    keep_t       exp_keep [$];
    logic        exp_last [$];
    logic        rx_done;
    logic        saw_stall;

    stream_kernel stream_kernel_i (.*);

    always #50 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic phit_t rand_vec(input int nbits);
        phit_t v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    // expected processed beat from one input beat and its coefficient
    function automatic void model_beat(input phit_t data, input keep_t keep, input phit_t coef,
                                       output phit_t pdata, output keep_t pkeep);
        logic [63:0] full_prod;
        logic        lane_ok;
        for (int k = 0; k < `LANES; k++) begin
            lane_ok   = (keep[k*4 +: 4] == 4'hf);
            full_prod = 64'(data[k*`LANE_W +: `LANE_W]) * 64'(coef[k*`LANE_W +: `LANE_W]);
            pdata[k*`LANE_W +: `LANE_W] = lane_ok ? full_prod[31:0] : 32'h0;
            pkeep[k*4 +: 4] = lane_ok ? 4'hf : 4'h0;
        end
    endfunction

    task automatic end_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_phit(input string name, input phit_t got, input phit_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_keep(input string name, input keep_t got, input keep_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // strobe loader done or kernel done, check the one-cycle state change
    task automatic toggle_steady(input logic enter);
        i_done_loader = enter;
        i_ap_done     = !enter;
        @(negedge clk);
        compare_bit("o_done_steady", o_done_steady, !enter);
        @(posedge clk);
        #1;
        i_done_loader = 1'b0;
        i_ap_done     = 1'b0;
        @(negedge clk);
        compare_bit("o_done_steady", o_done_steady, enter);
        @(posedge clk);
        #1;
    endtask

    task automatic load_coefs();
        for (int a = 0; a < `COEF_DEPTH; a++) begin
            i_coef_we     = 1'b1;
            i_coef_addr   = coef_addr_t'(a);
            i_coef_wdata  = rand_vec(`PHIT_W);
            coef_model[a] = i_coef_wdata;
            @(posedge clk);
            #1;
        end
        i_coef_we = 1'b0;
    endtask

    task automatic send_stream(input int n_beats, input logic partial);
        phit_t data;
        keep_t keep;
        logic  last;
        phit_t pdata;
        keep_t pkeep;
        logic  accepted;
        for (int n = 0; n < n_beats; n++) begin
            data = rand_vec(`PHIT_W);
            keep = '1;
            if (partial) begin
                for (int k = 0; k < `LANES; k++) begin
                    if (rand_vec(1) == 0) keep[k*4 +: 4] = 4'(rand_vec(4));
                end
            end
            last = (n == n_beats - 1) || (rand_vec(1) == 1);
            model_beat(data, keep, coef_model[n % `COEF_DEPTH], pdata, pkeep);
            exp_data.push_back(pdata);
            exp_keep.push_back(pkeep);
            exp_last.push_back(last);
            i_tdata_in  = data;
            i_tkeep_in  = keep;
            i_tlast_in  = last;
            i_tvalid_in = 1'b1;
            accepted    = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = o_tready_in;  // transfer on the coming edge
                @(posedge clk);
                #1;
            end
        end
        i_tvalid_in = 1'b0;
    endtask

    task automatic collect_beats(input int n_beats);
        int    got;
        phit_t ed;
        keep_t ek;
        logic  el;
        got = 0;
        while (got < n_beats) begin
            @(negedge clk);
            if (!i_tready_out && !o_tready_in) saw_stall = 1'b1;
            if (o_tvalid_out && i_tready_out) begin
                if (exp_data.size() == 0) begin
                    $display("output beat arrived with no beat expected");
                    end_with_failure();
                end else begin
                    ed = exp_data.pop_front();
                    ek = exp_keep.pop_front();
                    el = exp_last.pop_front();
                    compare_phit("o_tdata_out", o_tdata_out, ed);
                    compare_keep("o_tkeep_out", o_tkeep_out, ek);
                    compare_bit("o_tlast_out", o_tlast_out, el);
                    got++;
                end
            end
        end
        rx_done = 1'b1;
    endtask

    // long stall first, then output ready high about one cycle in four
    task automatic throttle_ready(input int hold_cycles);
        logic ready_next;
        i_tready_out = 1'b0;
        repeat (hold_cycles) begin
            @(posedge clk);
            #1;
        end
        while (!rx_done) begin
            @(negedge clk);
            ready_next = (rand_vec(2) == 0);
            @(posedge clk);
            #1;
            i_tready_out = ready_next;
        end
        i_tready_out = 1'b1;
    endtask

    task automatic run_steady(input int n_beats, input logic partial, input int hold_cycles);
        rx_done = 1'b0;
        toggle_steady(1'b1);
        fork
            send_stream(n_beats, partial);
            collect_beats(n_beats);
            if (hold_cycles > 0) throttle_ready(hold_cycles);
        join
        @(posedge clk);
        #1;
        @(negedge clk);
        compare_bit("o_tvalid_out", o_tvalid_out, 1'b0);  // nothing left over
        @(posedge clk);
        #1;
        toggle_steady(1'b0);
    endtask

    task automatic test_passthrough(input int n_beats);
        for (int n = 0; n < n_beats; n++) begin
            i_tdata_in   = rand_vec(`PHIT_W);
            i_tkeep_in   = keep_t'(rand_vec(`PHIT_W / 8));
            i_tlast_in   = (rand_vec(1) == 1);
            i_tvalid_in  = (rand_vec(1) == 1);
            i_tready_out = (rand_vec(1) == 1);
            @(negedge clk);
            compare_phit("o_tdata_out", o_tdata_out, i_tdata_in);
            compare_keep("o_tkeep_out", o_tkeep_out, i_tkeep_in);
            compare_bit("o_tvalid_out", o_tvalid_out, i_tvalid_in);
            compare_bit("o_tlast_out", o_tlast_out, i_tlast_in);
            compare_bit("o_tready_in", o_tready_in, i_tready_out);
            @(posedge clk);
            #1;
        end
        i_tvalid_in  = 1'b0;
        i_tready_out = 1'b1;
    endtask

    task automatic test_entry_exit();
        toggle_steady(1'b1);
        toggle_steady(1'b0);
        test_passthrough(8);
    endtask

    task automatic test_multiply();
        load_coefs();
        run_steady(20, 1'b0, 0);
    endtask

    task automatic test_partial_keep();
        run_steady(16, 1'b1, 0);
    endtask

    task automatic test_back_pressure();
        saw_stall = 1'b0;
        run_steady(40, 1'b0, 60);
        if (!saw_stall) begin
            $display("o_tready_in never dropped while output ready was held low");
            end_with_failure();
        end
    endtask

    always @(negedge clk) begin
        if (stream_kernel_i.stream_kernel_checker_i.assert_failures != 0) begin
            $display("a bound assertion on the DUT ports failed");
            end_with_failure();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        end_with_failure();
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        i_done_loader = 1'b0;
        i_ap_done     = 1'b0;
        i_coef_we     = 1'b0;
        i_coef_addr   = '0;
        i_coef_wdata  = '0;
        i_tdata_in    = '0;
        i_tkeep_in    = '0;
        i_tvalid_in   = 1'b0;
        i_tlast_in    = 1'b0;
        i_tready_out  = 1'b1;
        rx_done       = 1'b0;
        saw_stall     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_passthrough(24);
        test_entry_exit();
        test_multiply();
        test_partial_keep();
        test_back_pressure();
        if (stream_kernel_i.stream_kernel_checker_i.assert_failures != 0) begin
            $display("bound assertions reported failures");
            end_with_failure();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/kernel_pkg.sv
design/sync_fifo.sv
design/stream_in_buffer.sv
design/coef_bank.sv
design/lane_multiplier.sv
design/steady_bypass.sv
design/stream_kernel.sv
tb/stream_kernel_checker.sv
tb/tb_stream_kernel.sv

// File: Bender.yml
package:
  name: stream_kernel

sources:
  - include_dirs:
      - design
    files:
      - design/kernel_pkg.sv
      - design/sync_fifo.sv
      - design/stream_in_buffer.sv
      - design/coef_bank.sv
      - design/lane_multiplier.sv
      - design/steady_bypass.sv
      - design/stream_kernel.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/stream_kernel_checker.sv
      - tb/tb_stream_kernel.sv
